// File: Makefile
SIM       = verilator
FLAGS     = --binary --timing -Wno-fatal
TOP       = tb_hole_wall
FILELIST  = project.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = Test completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: game_fsm.sv
`timescale 1ns/1ps

module game_fsm #(
    parameter int PASS_SCORE = 300,
    parameter int ROUNDS     = 5
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 btn_start,
    input  logic                 pattern_valid,
    input  logic                 frame_end,
    input  logic                 expired,
    input  logic                 gate_ready,
    input  game_pkg::score_t     advantage,
    input  game_pkg::score_t     penalty,
    input  game_pkg::score_t     round_score,
    output logic                 count_frames,
    output logic                 count_cycles,
    output logic                 gate_active,
    output logic                 tally_clear,
    output logic                 tally_on,
    output game_pkg::phase_t     phase,
    output logic                 pattern_load,
    output logic [2:0]           pattern_num,
    output logic                 frame_stop,
    output logic [1:0]           sound_option,
    output game_pkg::score_t     score,
    output game_pkg::txt_mode_t  txt_mode
);

    import game_pkg::*;

    typedef enum logic [3:0] {
        IDLE,
        GATE,
        LOAD,
        WAIT_PATTERN,
        POSE,
        SCORE,
        SHOW_ADV,
        SHOW_PEN,
        SHOW_ROUND,
        VERDICT,
        FINAL
    } state_t;

    state_t state, state_next;
    score_t total;
    logic   passed;
    logic   round_pass;

    assign round_pass = (round_score >= PASS_SCORE);

    always_comb begin
        state_next = state;
        case (state)
            IDLE:         if (btn_start) state_next = GATE;
            GATE:         if (gate_ready) state_next = LOAD;
            LOAD:         state_next = WAIT_PATTERN;
            WAIT_PATTERN: if (pattern_valid) state_next = POSE;
            POSE:         if (expired) state_next = SCORE;  // lands on a frame_end
            SCORE:        if (frame_end) state_next = SHOW_ADV;
            SHOW_ADV:     if (expired) state_next = SHOW_PEN;
            SHOW_PEN:     if (expired) state_next = SHOW_ROUND;
            SHOW_ROUND:   if (expired) state_next = VERDICT;
            VERDICT: begin
                if (expired) begin
                    if (passed && (int'(pattern_num) < ROUNDS - 1)) begin
                        state_next = LOAD;
                    end else begin
                        state_next = FINAL;
                    end
                end
            end
            FINAL:        if (btn_start) state_next = IDLE;
            default:      state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state        <= IDLE;
            pattern_num  <= '0;
            frame_stop   <= 1'b0;
            sound_option <= 2'b00;
            total        <= '0;
            passed       <= 1'b0;
        end else begin
            state        <= state_next;
            sound_option <= 2'b00;
            if (state == WAIT_PATTERN && pattern_valid) frame_stop <= 1'b0;
            if (state == POSE && expired) frame_stop <= 1'b1;  // freeze for scoring
            if (state == SHOW_PEN && expired) total <= total + round_score;
            if (state == SHOW_ROUND && expired) begin
                passed       <= round_pass;
                sound_option <= round_pass ? SOUND_PASS : SOUND_FAIL;
            end
            if (state == VERDICT && expired && passed) pattern_num <= pattern_num + 1'b1;
            if (state == FINAL && btn_start) begin
                total       <= '0;
                pattern_num <= '0;
            end
        end
    end

    assign count_frames = (state == POSE);
    assign count_cycles = (state inside {SHOW_ADV, SHOW_PEN, SHOW_ROUND, VERDICT});
    assign gate_active  = (state == GATE);
    assign pattern_load = (state == LOAD);
    assign tally_clear  = (state == LOAD);  // fresh tallies each round
    assign tally_on     = (state == SCORE);

    always_comb begin
        phase    = PH_POSE;
        txt_mode = TXT_BLANK;
        score    = '0;
        case (state)
            IDLE: begin
                phase    = PH_CAMERA;
                txt_mode = TXT_TITLE;
            end
            GATE: begin
                phase    = PH_GATE;
                txt_mode = TXT_TITLE;
            end
            LOAD, WAIT_PATTERN: phase = PH_CAMERA;
            POSE:     txt_mode = TXT_COUNTDOWN;
            SHOW_ADV: begin
                txt_mode = TXT_ADVANTAGE;
                score    = advantage;
            end
            SHOW_PEN: begin
                txt_mode = TXT_PENALTY;
                score    = penalty;
            end
            SHOW_ROUND: begin
                txt_mode = TXT_ROUND;
                score    = round_score;
            end
            VERDICT: begin
                txt_mode = passed ? TXT_PASS : TXT_FAIL;
                score    = round_score;
            end
            FINAL: begin
                phase    = PH_CAMERA;
                txt_mode = TXT_FINAL;
                score    = total;
            end
            default: ;
        endcase
    end

endmodule

// File: game_pkg.sv
package game_pkg;

    // what the pixel mixer paints under the text
    typedef enum logic [1:0] {
        PH_CAMERA,
        PH_GATE,
        PH_POSE
    } phase_t;

    // codes understood by the text overlay
    typedef enum logic [3:0] {
        TXT_TITLE     = 4'd0,
        TXT_BLANK     = 4'd1,
        TXT_PENALTY   = 4'd2,
        TXT_ROUND     = 4'd3,
        TXT_COUNTDOWN = 4'd5,
        TXT_PASS      = 4'd6,
        TXT_FAIL      = 4'd7,
        TXT_ADVANTAGE = 4'd8,
        TXT_FINAL     = 4'd9
    } txt_mode_t;

    typedef logic signed [13:0] score_t;  // shown on the overlay
    typedef logic [18:0] tally_t;         // full frame of pixels fits

    // sound player request codes
    localparam logic [1:0] SOUND_PASS = 2'b01;
    localparam logic [1:0] SOUND_FAIL = 2'b10;

endpackage

// File: hole_wall_top.sv
`timescale 1ns/1ps

module hole_wall_top #(
    parameter int H_PIXELS    = 640,
    parameter int V_PIXELS    = 480,
    parameter int GATE_PIXELS = 800,
    parameter int GATE_FRAMES = 80,
    parameter int POSE_FRAMES = 450,
    parameter int HOLD_CYCLES = 250_000_000,
    parameter int SCORE_SHIFT = 6,
    parameter int PASS_SCORE  = 300,
    parameter int ROUNDS      = 5
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 pixel_en,
    input  logic                 de,
    input  video_pkg::coord_t    x_pixel,
    input  video_pkg::coord_t    y_pixel,
    input  logic                 chroma,
    input  logic                 in_polygon,
    input  video_pkg::chan_t     cam_red,
    input  video_pkg::chan_t     cam_green,
    input  video_pkg::chan_t     cam_blue,
    input  logic [1:0]           txt_out,
    input  logic                 btn_start,
    input  logic                 pattern_valid,
    output logic                 pattern_load,
    output logic [2:0]           pattern_num,
    output logic                 frame_stop,
    output logic [1:0]           sound_option,
    output game_pkg::score_t     score,
    output game_pkg::txt_mode_t  txt_mode,
    output video_pkg::chan_t     red,
    output video_pkg::chan_t     green,
    output video_pkg::chan_t     blue
);

    import game_pkg::*;

    logic   frame_end;
    logic   expired;
    logic   count_frames;
    logic   count_cycles;
    logic   gate_active;
    logic   gate_lit;
    logic   gate_ready;
    logic   tally_clear;
    logic   tally_on;
    score_t advantage;
    score_t penalty;
    score_t round_score;
    phase_t phase;

    phase_timer #(
        .H_PIXELS(H_PIXELS), .V_PIXELS(V_PIXELS),
        .POSE_FRAMES(POSE_FRAMES), .HOLD_CYCLES(HOLD_CYCLES)
    ) u_phase_timer (
        .clk(clk), .reset(reset), .pixel_en(pixel_en), .x_pixel(x_pixel),
        .y_pixel(y_pixel), .count_frames(count_frames), .count_cycles(count_cycles),
        .frame_end(frame_end), .expired(expired)
    );

    start_gate #(
        .H_PIXELS(H_PIXELS), .V_PIXELS(V_PIXELS),
        .GATE_PIXELS(GATE_PIXELS), .GATE_FRAMES(GATE_FRAMES)
    ) u_start_gate (
        .clk(clk), .reset(reset), .gate_active(gate_active), .pixel_en(pixel_en),
        .frame_end(frame_end), .x_pixel(x_pixel), .y_pixel(y_pixel), .chroma(chroma),
        .gate_lit(gate_lit), .gate_ready(gate_ready)
    );

    pose_scorer #(
        .SCORE_SHIFT(SCORE_SHIFT)
    ) u_pose_scorer (
        .clk(clk), .reset(reset), .tally_clear(tally_clear), .tally_on(tally_on),
        .pixel_en(pixel_en), .chroma(chroma), .in_polygon(in_polygon),
        .advantage(advantage), .penalty(penalty), .round_score(round_score)
    );

    game_fsm #(
        .PASS_SCORE(PASS_SCORE), .ROUNDS(ROUNDS)
    ) u_game_fsm (
        .clk(clk), .reset(reset), .btn_start(btn_start), .pattern_valid(pattern_valid),
        .frame_end(frame_end), .expired(expired), .gate_ready(gate_ready),
        .advantage(advantage), .penalty(penalty), .round_score(round_score),
        .count_frames(count_frames), .count_cycles(count_cycles),
        .gate_active(gate_active), .tally_clear(tally_clear), .tally_on(tally_on),
        .phase(phase), .pattern_load(pattern_load), .pattern_num(pattern_num),
        .frame_stop(frame_stop), .sound_option(sound_option), .score(score),
        .txt_mode(txt_mode)
    );

    pixel_mixer u_pixel_mixer (
        .clk(clk), .reset(reset), .phase(phase), .de(de), .txt_out(txt_out),
        .chroma(chroma), .in_polygon(in_polygon), .gate_lit(gate_lit),
        .cam_red(cam_red), .cam_green(cam_green), .cam_blue(cam_blue),
        .red(red), .green(green), .blue(blue)
    );

endmodule

// File: phase_timer.sv
`timescale 1ns/1ps

module phase_timer #(
    parameter int H_PIXELS    = 640,
    parameter int V_PIXELS    = 480,
    parameter int POSE_FRAMES = 450,
    parameter int HOLD_CYCLES = 250_000_000
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              pixel_en,
    input  video_pkg::coord_t x_pixel,
    input  video_pkg::coord_t y_pixel,
    input  logic              count_frames,
    input  logic              count_cycles,
    output logic              frame_end,
    output logic              expired
);

    import video_pkg::*;

    localparam int CNT_MAX = (POSE_FRAMES > HOLD_CYCLES) ? POSE_FRAMES : HOLD_CYCLES;
    localparam int CNT_W   = $clog2(CNT_MAX + 1);

    logic [CNT_W-1:0] cnt;
    logic             step;
    logic [CNT_W-1:0] last;

    assign frame_end = pixel_en && (x_pixel == coord_t'(H_PIXELS - 1))
                                && (y_pixel == coord_t'(V_PIXELS - 1));

    // one counter for frames or clocks
    assign step    = count_frames ? frame_end : count_cycles;
    assign last    = count_frames ? CNT_W'(POSE_FRAMES - 1) : CNT_W'(HOLD_CYCLES - 1);
    assign expired = step && (cnt == last);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cnt <= '0;
        end else if ((!count_frames && !count_cycles) || expired) begin
            cnt <= '0;  // idle or restart for back to back holds
        end else if (step) begin
            cnt <= cnt + 1'b1;
        end
    end

endmodule

// File: pixel_mixer.sv
`timescale 1ns/1ps

module pixel_mixer (
    input  logic              clk,
    input  logic              reset,
    input  game_pkg::phase_t  phase,
    input  logic              de,
    input  logic [1:0]        txt_out,
    input  logic              chroma,
    input  logic              in_polygon,
    input  logic              gate_lit,
    input  video_pkg::chan_t  cam_red,
    input  video_pkg::chan_t  cam_green,
    input  video_pkg::chan_t  cam_blue,
    output video_pkg::chan_t  red,
    output video_pkg::chan_t  green,
    output video_pkg::chan_t  blue
);

    import video_pkg::*;
    import game_pkg::*;

    chan_t [2:0] cam;
    chan_t [2:0] mix;
    chan_t [2:0] mix_reg;

    assign cam = {cam_red, cam_green, cam_blue};

    always_comb begin
        if (txt_out[1]) begin
            mix = COL_BLACK;  // glyph outline
        end else if (txt_out[0]) begin
            mix = COL_WHITE;
        end else begin
            case (phase)
                PH_GATE: mix = gate_lit ? COL_RED : cam;
                PH_POSE: begin
                    if (in_polygon) begin
                        mix = chroma ? COL_CYAN : cam;  // hole open vs filled
                    end else begin
                        mix = chroma ? COL_YELLOW : COL_RED;  // wall vs body outside
                    end
                end
                default: mix = cam;
            endcase
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            mix_reg <= COL_BLACK;
        end else begin
            mix_reg <= mix;
        end
    end

    // blank outside the active area
    assign {red, green, blue} = de ? mix_reg : COL_BLACK;

endmodule

// File: pose_scorer.sv
`timescale 1ns/1ps

module pose_scorer #(
    parameter int SCORE_SHIFT = 6
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              tally_clear,
    input  logic              tally_on,
    input  logic              pixel_en,
    input  logic              chroma,
    input  logic              in_polygon,
    output game_pkg::score_t  advantage,
    output game_pkg::score_t  penalty,
    output game_pkg::score_t  round_score
);

    import game_pkg::*;

    tally_t adv_tally;
    tally_t pen_tally;
    tally_t adv_shift;
    tally_t pen_shift;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            adv_tally <= '0;
            pen_tally <= '0;
        end else if (tally_clear) begin
            adv_tally <= '0;
            pen_tally <= '0;
        end else if (tally_on && pixel_en && !chroma) begin
            // only person pixels count
            if (in_polygon) begin
                adv_tally <= adv_tally + 1'b1;
            end else begin
                pen_tally <= pen_tally + 1'b1;
            end
        end
    end

    assign adv_shift = adv_tally >> SCORE_SHIFT;
    assign pen_shift = pen_tally >> SCORE_SHIFT;

    assign advantage   = adv_shift[13:0];
    assign penalty     = pen_shift[13:0];
    assign round_score = advantage - penalty;  // may go negative

endmodule

// File: project.f
video_pkg.sv
game_pkg.sv
phase_timer.sv
start_gate.sv
pose_scorer.sv
game_fsm.sv
pixel_mixer.sv
hole_wall_top.sv
tb_hole_wall.sv

// File: start_gate.sv
`timescale 1ns/1ps

module start_gate #(
    parameter int H_PIXELS    = 640,
    parameter int V_PIXELS    = 480,
    parameter int GATE_PIXELS = 800,
    parameter int GATE_FRAMES = 80
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              gate_active,
    input  logic              pixel_en,
    input  logic              frame_end,
    input  video_pkg::coord_t x_pixel,
    input  video_pkg::coord_t y_pixel,
    input  logic              chroma,
    output logic              gate_lit,
    output logic              gate_ready
);

    import video_pkg::*;

    // central half of the frame
    localparam int BOX_X0 = H_PIXELS / 4;
    localparam int BOX_X1 = H_PIXELS - BOX_X0;
    localparam int BOX_Y0 = V_PIXELS / 4;
    localparam int BOX_Y1 = V_PIXELS - BOX_Y0;
    localparam int BOX_H  = BOX_Y1 - BOX_Y0;
    localparam int PIX_W  = $clog2(H_PIXELS * V_PIXELS + 1);
    localparam int FILL_W = $clog2(GATE_FRAMES + 1);

    logic              in_box;
    logic              occupied;
    logic [PIX_W-1:0]  pix_cnt;
    logic [FILL_W-1:0] fill;

    assign in_box = (x_pixel >= coord_t'(BOX_X0)) && (x_pixel < coord_t'(BOX_X1))
                 && (y_pixel >= coord_t'(BOX_Y0)) && (y_pixel < coord_t'(BOX_Y1));

    assign occupied = (pix_cnt >= PIX_W'(GATE_PIXELS));

    // bar rises from the bottom edge of the box
    assign gate_lit = in_box
                   && ((BOX_Y1 - int'(y_pixel)) * GATE_FRAMES <= int'(fill) * BOX_H);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pix_cnt    <= '0;
            fill       <= '0;
            gate_ready <= 1'b0;
        end else begin
            gate_ready <= 1'b0;
            if (!gate_active) begin
                pix_cnt <= '0;
                fill    <= '0;
            end else if (frame_end) begin
                pix_cnt <= '0;
                if (occupied) begin
                    if (fill == FILL_W'(GATE_FRAMES - 1)) begin
                        fill       <= '0;
                        gate_ready <= 1'b1;  // full bar
                    end else begin
                        fill <= fill + 1'b1;
                    end
                end else if (fill != '0) begin
                    fill <= fill - 1'b1;  // person left the box
                end
            end else if (pixel_en && in_box && !chroma) begin
                pix_cnt <= pix_cnt + 1'b1;
            end
        end
    end

endmodule

// File: tb_hole_wall.sv
`timescale 1ns/1ps

module tb_hole_wall;

    import video_pkg::*;
    import game_pkg::*;

    localparam int H_PIXELS    = 16;
    localparam int V_PIXELS    = 12;
    localparam int GATE_PIXELS = 10;
    localparam int GATE_FRAMES = 3;
    localparam int POSE_FRAMES = 2;
    localparam int HOLD_CYCLES = 20;
    localparam int SCORE_SHIFT = 2;
    localparam int PASS_SCORE  = 3;
    localparam int ROUNDS      = 3;
    localparam int LIMIT       = 16 * H_PIXELS * V_PIXELS;  // clocks allowed per wait

    localparam int M_QUIET  = 0;
    localparam int M_COLOUR = 1;
    localparam int M_GATE   = 2;
    localparam int M_SCORE  = 3;

    logic                clk;
    logic                reset;
    logic                pixel_en   = 1'b0;
    logic                de         = 1'b1;
    coord_t              x_pixel    = coord_t'(H_PIXELS - 1);
    coord_t              y_pixel    = coord_t'(V_PIXELS - 1);
    logic                chroma     = 1'b1;
    logic                in_polygon = 1'b0;
    chan_t               cam_red    = '0;
    chan_t               cam_green  = '0;
    chan_t               cam_blue   = '0;
    logic [1:0]          txt_out    = 2'b00;
    logic                btn_start;
    logic                pattern_valid;
    logic                pattern_load;
    logic [2:0]          pattern_num;
    logic                frame_stop;
    logic [1:0]          sound_option;
    score_t              score;
    txt_mode_t           txt_mode;
    chan_t               red;
    chan_t               green;
    chan_t               blue;

    integer      seed      = 16;
    int          stim_mode = M_QUIET;
    int          bias      = 2;
    logic [31:0] rnd;
    logic        scoring   = 1'b0;
    logic        stop_seen = 1'b0;
    int          adv_cnt   = 0;
    int          pen_cnt   = 0;

    int          game;
    int          round;
    int          k;
    int          n;
    int          delay;
    int          exp_num;
    int          exp_adv;
    int          exp_pen;
    int          exp_round;
    int          total;
    logic        passed;
    logic        done;
    logic [31:0] r;
    logic [1:0]  prev_txt;
    logic [11:0] prev_cam;
    logic [11:0] exp_col;

    hole_wall_top #(
        .H_PIXELS(H_PIXELS), .V_PIXELS(V_PIXELS), .GATE_PIXELS(GATE_PIXELS),
        .GATE_FRAMES(GATE_FRAMES), .POSE_FRAMES(POSE_FRAMES), .HOLD_CYCLES(HOLD_CYCLES),
        .SCORE_SHIFT(SCORE_SHIFT), .PASS_SCORE(PASS_SCORE), .ROUNDS(ROUNDS)
    ) u_hole_wall_top (
        .clk(clk), .reset(reset), .pixel_en(pixel_en), .de(de), .x_pixel(x_pixel),
        .y_pixel(y_pixel), .chroma(chroma), .in_polygon(in_polygon), .cam_red(cam_red),
        .cam_green(cam_green), .cam_blue(cam_blue), .txt_out(txt_out),
        .btn_start(btn_start), .pattern_valid(pattern_valid), .pattern_load(pattern_load),
        .pattern_num(pattern_num), .frame_stop(frame_stop), .sound_option(sound_option),
        .score(score), .txt_mode(txt_mode), .red(red), .green(green), .blue(blue)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // raster with a pixel on every second clock and the tally model
    always @(negedge clk) begin
        rnd = $random(seed);
        if (stim_mode == M_COLOUR) begin
            de        = rnd[0];
            txt_out   = rnd[2:1];
            cam_red   = rnd[6:3];
            cam_green = rnd[10:7];
            cam_blue  = rnd[14:11];
        end else begin
            de      = 1'b1;
            txt_out = 2'b00;
        end
        if (frame_stop && !stop_seen) begin
            scoring = 1'b1;  // next whole frame is scored
            adv_cnt = 0;
            pen_cnt = 0;
        end
        stop_seen = frame_stop;
        pixel_en  = !pixel_en;
        if (pixel_en) begin
            if (x_pixel == coord_t'(H_PIXELS - 1)) begin
                x_pixel = '0;
                y_pixel = (y_pixel == coord_t'(V_PIXELS - 1)) ? '0 : y_pixel + 1'b1;
            end else begin
                x_pixel = x_pixel + 1'b1;
            end
            case (stim_mode)
                M_GATE:  chroma = 1'b0;  // person fills the box
                M_SCORE: chroma = rnd[15];
                default: chroma = 1'b1;
            endcase
            in_polygon = (int'(rnd[17:16]) < bias);
            if (scoring && !chroma) begin
                if (in_polygon) begin
                    adv_cnt++;
                end else begin
                    pen_cnt++;
                end
            end
            if (x_pixel == coord_t'(H_PIXELS - 1) && y_pixel == coord_t'(V_PIXELS - 1)) begin
                scoring = 1'b0;
            end
        end
    end

    function automatic logic [11:0] mix_rule(input logic [1:0] txt, input logic [11:0] cam);
        if (txt[1]) begin
            return 12'h000;  // outline
        end else if (txt[0]) begin
            return 12'hFFF;
        end
        return cam;
    endfunction

    task automatic step_cycle();
        @(posedge clk);
        #10;
    endtask

    task automatic timeout_fail(input string what);
        $display("Timeout while waiting for %s at %0t", what, $time);
        $display("Test failed");
        $fatal(1, "wait did not finish");
    endtask

    task automatic check(input int got, input int exp, input string what);
        if (got !== exp) begin
            $display("** Error at %0t: %s is %0d, expected %0d", $time, what, got, exp);
            $display("Test failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic press_start();
        @(negedge clk);
        btn_start = 1'b1;
        @(negedge clk);
        btn_start = 1'b0;
        step_cycle();
    endtask

    task automatic wait_for_txt(input txt_mode_t mode);
        int cnt;
        cnt = 0;
        while (txt_mode != mode) begin
            step_cycle();
            cnt++;
            if (cnt > LIMIT) timeout_fail($sformatf("txt_mode %0d", mode));
        end
    endtask

    task automatic check_hold(input txt_mode_t mode, input int exp);
        int cnt;
        cnt = 0;
        check(txt_mode, mode, "display text mode");
        while (txt_mode == mode) begin
            check(score, exp, "displayed score");
            cnt++;
            if (cnt > LIMIT) timeout_fail("end of display");
            step_cycle();
        end
        check(cnt, HOLD_CYCLES, "display length");
    endtask

    initial begin
        reset         = 1'b1;
        btn_start     = 1'b0;
        pattern_valid = 1'b0;
        repeat (10) @(posedge clk);
        #10;
        check(pattern_load, 0, "pattern_load in reset");
        check(frame_stop, 0, "frame_stop in reset");
        check(sound_option, 0, "sound_option in reset");
        check(score, 0, "score in reset");
        check(txt_mode, TXT_TITLE, "txt_mode in reset");
        check(pattern_num, 0, "pattern_num in reset");
        check({red, green, blue}, 0, "colour in reset");
        @(negedge clk);
        reset = 1'b0;
        step_cycle();
        for (game = 0; game < 2; game++) begin
            check(txt_mode, TXT_TITLE, "idle text mode");
            stim_mode = M_COLOUR;
            for (k = 0; k < 64; k++) begin
                @(negedge clk);
                #10;
                if (k > 0) begin
                    exp_col = de ? mix_rule(prev_txt, prev_cam) : 12'h000;
                    check({red, green, blue}, exp_col, "idle pixel colour");
                end
                prev_txt = txt_out;
                prev_cam = {cam_red, cam_green, cam_blue};
            end
            stim_mode = M_GATE;
            step_cycle();
            press_start();
            exp_num = 0;
            total   = 0;
            round   = 0;
            done    = 1'b0;
            while (!done) begin
                n = 0;
                while (pattern_load !== 1'b1) begin
                    step_cycle();
                    n++;
                    if (n > LIMIT) timeout_fail("pattern_load");
                end
                check(pattern_num, exp_num, "pattern_num at load");
                step_cycle();
                check(pattern_load, 0, "pattern_load after one cycle");
                stim_mode = M_SCORE;
                r         = $random(seed);
                if (game == 0) begin
                    bias = 3;  // good poses run to the round limit
                end else begin
                    bias = 1 + int'(r[1:0]) % 3;  // pose quality of this round
                end
                delay     = int'(r[5:2]);
                repeat (delay) step_cycle();
                @(negedge clk);
                pattern_valid = 1'b1;
                @(negedge clk);
                pattern_valid = 1'b0;
                step_cycle();
                check(txt_mode, TXT_COUNTDOWN, "pose text mode");
                check(frame_stop, 0, "frame_stop after pattern_valid");
                n = 0;
                while (frame_stop !== 1'b1) begin
                    step_cycle();
                    n++;
                    if (n > LIMIT) timeout_fail("frame_stop");
                end
                wait_for_txt(TXT_ADVANTAGE);
                exp_adv   = adv_cnt >> SCORE_SHIFT;
                exp_pen   = pen_cnt >> SCORE_SHIFT;
                exp_round = exp_adv - exp_pen;
                total     = total + exp_round;
                check_hold(TXT_ADVANTAGE, exp_adv);
                check_hold(TXT_PENALTY, exp_pen);
                check_hold(TXT_ROUND, exp_round);
                passed = (exp_round >= PASS_SCORE);
                check(sound_option, passed ? SOUND_PASS : SOUND_FAIL, "sound at verdict");
                check(txt_mode, passed ? TXT_PASS : TXT_FAIL, "verdict text mode");
                step_cycle();
                check(sound_option, 0, "sound after one cycle");
                if (passed) exp_num++;
                round++;
                done = !passed || (round == ROUNDS);
            end
            stim_mode = M_QUIET;
            wait_for_txt(TXT_FINAL);
            check(score, total, "final total");
            check(pattern_num, exp_num, "final pattern_num");
            press_start();
            check(txt_mode, TXT_TITLE, "text mode after restart");
            check(pattern_num, 0, "pattern_num after restart");
        end
        $display("Test completed successfully");
        $finish;
    end

endmodule

// File: video_pkg.sv
package video_pkg;

    typedef logic [9:0] coord_t;  // x or y position
    typedef logic [3:0] chan_t;   // one of r, g, b

    // overlay colours with red in the top channel
    localparam chan_t [2:0] COL_BLACK = {
        4'h0,
        4'h0,
        4'h0
    };
    localparam chan_t [2:0] COL_WHITE = {
        4'hF,
        4'hF,
        4'hF
    };
    localparam chan_t [2:0] COL_RED = {
        4'hF,
        4'h0,
        4'h0
    };
    localparam chan_t [2:0] COL_YELLOW = {
        4'hF,
        4'hF,
        4'h0
    };
    localparam chan_t [2:0] COL_CYAN = {
        4'h0,
        4'hA,
        4'hF
    };

endpackage
